//--- verilog/bg_pkg.sv
////////////////////
// types and constants shared by the background layer
// import with bg_pkg::* in the module header
////////////////////
package bg_pkg;

	typedef logic [15:0] word_t;   // memory and register word
	typedef logic [7:0]  tile_t;   // tile index from the map
	typedef logic [3:0]  pixel_t;  // 4bpp pixel
	typedef logic [7:0]  color_t;  // palette index to the display

	// CPU register map
	typedef enum logic [3:0] {
		REG_CTRL         = 4'd0,  // bit 0 enable, 2:1 stride code, 7:4 palette high
		REG_SCROLL_X     = 4'd1,
		REG_SCROLL_Y     = 4'd2,
		REG_MAP_BASE     = 4'd3,  // word address
		REG_TILESET_BASE = 4'd4   // word address
	} reg_addr_e;

	// no tile data fetched for this index, pixels read as zero
	localparam tile_t TRANSPARENT_TILE = 8'hFF;

	localparam int TILE_PIXELS = 16;

	// bytes per map row at stride code 0, doubled per code step
	localparam int MAP_ROW_BYTES = 32;

endpackage

//--- verilog/bg_regs.sv
`timescale 1ns/1ns
////////////////////
// CPU side register file of the background layer
// single cycle writes, values take effect the cycle after reg_wr
// late_line is sticky until the next REG_CTRL write
////////////////////
module bg_regs import bg_pkg::*; (
	input  logic      CLK,
	input  logic      RSTb,
	input  reg_addr_e reg_addr,
	input  word_t     reg_wdata,
	input  logic      reg_wr,
	input  logic      late_set,
	output logic      enable,
	output logic [1:0] stride_code,
	output pixel_t    pal_hi,
	output word_t     scroll_x,
	output word_t     scroll_y,
	output word_t     map_base,
	output word_t     tileset_base,
	output logic      late_line
);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable       <= 1'b0;
			stride_code  <= 2'd0;
			pal_hi       <= '0;
			scroll_x     <= '0;
			scroll_y     <= '0;
			map_base     <= '0;
			tileset_base <= '0;
		end else if (reg_wr) begin
			case (reg_addr)
				REG_CTRL: begin
					enable      <= reg_wdata[0];
					stride_code <= reg_wdata[2:1];
					pal_hi      <= reg_wdata[7:4];
				end
				REG_SCROLL_X:     scroll_x     <= reg_wdata;
				REG_SCROLL_Y:     scroll_y     <= reg_wdata;
				REG_MAP_BASE:     map_base     <= reg_wdata;
				REG_TILESET_BASE: tileset_base <= reg_wdata;
				default: ;
			endcase
		end
	end

	// a fresh abort wins over a clear in the same cycle
	always_ff @(posedge CLK) begin
		if (!RSTb)
			late_line <= 1'b0;
		else if (late_set)
			late_line <= 1'b1;
		else if (reg_wr && reg_addr == REG_CTRL)
			late_line <= 1'b0;
	end

	a_reg_addr_defined: assert property (@(posedge CLK) disable iff (!RSTb)
		reg_wr |-> reg_addr <= REG_TILESET_BASE);

endmodule

//--- verilog/tile_fetcher.sv
`timescale 1ns/1ns
////////////////////
// background line fetcher
// on each enabled h_tick it walks LINE_PIXELS/16 + 1 tile columns,
// reads the map byte and the four data words of the tile row, and
// writes them to the back scanline buffer, one word per 4 pixels
////////////////////
module tile_fetcher import bg_pkg::*; #(
	parameter  int LINE_PIXELS = 320,
	localparam int AW = $clog2((LINE_PIXELS + TILE_PIXELS) / 4)
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          enable,
	input  logic          h_tick,
	input  logic [9:0]    line_y,
	input  logic [1:0]    stride_code,
	input  word_t         scroll_x,
	input  word_t         scroll_y,
	input  word_t         map_base,
	input  word_t         tileset_base,
	input  word_t         mem_data,
	input  logic          mem_ack,
	output word_t         mem_addr,
	output logic          mem_req,
	output logic          wr_buf,
	output logic [AW-1:0] wr_addr,
	output word_t         wr_data,
	output logic          wr_en,
	output logic          late_set
);

	localparam int NCOLS = LINE_PIXELS / TILE_PIXELS + 1;
	localparam int CW = AW - 2;  // 4 buffer words per column
	localparam int BUF_WORDS = NCOLS * 4;
	localparam int ROW_SHIFT = $clog2(MAP_ROW_BYTES);

	typedef enum logic [2:0] {S_IDLE, S_FLUSH, S_MAP, S_DATA, S_ZERO} state_e;

	state_e        state;
	logic [CW-1:0] col_cnt;
	logic [1:0]    w_cnt;     // data word within the tile row
	tile_t         tile_r;

	// line parameters, captured at h_tick
	logic [11:0] row_r;
	logic [3:0]  ty_r;
	logic [7:0]  coarse_r;
	logic [1:0]  stride_r;
	word_t       map_base_r;
	word_t       tileset_base_r;

	logic [15:0] v_sum;
	logic [7:0]  col_mask;
	logic [7:0]  map_col;
	logic [16:0] map_byte;    // byte address into the map
	tile_t       map_tile;
	word_t       data_addr;
	logic        last_col;
	logic        word_done;

	assign v_sum    = scroll_y + {6'd0, line_y};
	assign col_mask = 8'hFF >> (2'd3 - stride_r);  // wrap at the map stride
	assign map_col  = (coarse_r + 8'(col_cnt)) & col_mask;
	assign map_byte = {map_base_r, 1'b0}
		+ ({5'd0, row_r} << (ROW_SHIFT + int'(stride_r)))
		+ {9'd0, map_col};
	assign map_tile = map_byte[0] ? mem_data[15:8] : mem_data[7:0];  // even byte low

	// bank select 7:4, tile row, column in bank 3:0, word
	assign data_addr = tileset_base_r + {2'b00, tile_r[7:4], ty_r, tile_r[3:0], w_cnt};

	assign last_col  = (col_cnt == CW'(NCOLS - 1));
	assign word_done = (state == S_ZERO) || (state == S_DATA && mem_req && mem_ack);

	always_ff @(posedge CLK) begin
		if (h_tick && enable) begin
			row_r          <= v_sum[15:4];
			ty_r           <= v_sum[3:0];
			coarse_r       <= scroll_x[11:4];
			stride_r       <= stride_code;
			map_base_r     <= map_base;
			tileset_base_r <= tileset_base;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state    <= S_IDLE;
			mem_req  <= 1'b0;
			wr_buf   <= 1'b0;
			wr_en    <= 1'b0;
			late_set <= 1'b0;
			col_cnt  <= '0;
			w_cnt    <= 2'd0;
		end else begin
			wr_en    <= 1'b0;
			late_set <= 1'b0;
			if (h_tick && enable) begin
				late_set <= (state != S_IDLE);  // previous line not finished
				wr_buf   <= ~wr_buf;
				col_cnt  <= '0;
				if (mem_req && !mem_ack) begin
					state <= S_FLUSH;  // open request must still see its ack
				end else begin
					mem_req <= 1'b0;
					state   <= S_MAP;
				end
			end else begin
				case (state)
					S_FLUSH: begin
						if (mem_ack) begin
							mem_req <= 1'b0;
							state   <= S_MAP;
						end
					end
					S_MAP: begin
						if (!mem_req) begin
							mem_req  <= 1'b1;
							mem_addr <= map_byte[16:1];
						end else if (mem_ack) begin
							mem_req <= 1'b0;
							tile_r  <= map_tile;
							w_cnt   <= 2'd0;
							state   <= (map_tile == TRANSPARENT_TILE) ? S_ZERO : S_DATA;
						end
					end
					S_DATA: begin
						if (!mem_req) begin
							mem_req  <= 1'b1;
							mem_addr <= data_addr;
						end else if (mem_ack) begin
							mem_req <= 1'b0;
						end
					end
					default: ;
				endcase

				// one buffer word per data ack, or per cycle for a blank tile
				if (word_done) begin
					wr_en   <= 1'b1;
					wr_addr <= {col_cnt, w_cnt};
					wr_data <= (state == S_ZERO) ? '0 : mem_data;
					w_cnt   <= w_cnt + 2'd1;
					if (w_cnt == 2'd3) begin
						if (last_col) begin
							state <= S_IDLE;
						end else begin
							col_cnt <= col_cnt + 1'b1;
							state   <= S_MAP;
						end
					end
				end
			end
		end
	end

	a_addr_held: assert property (@(posedge CLK) disable iff (!RSTb)
		mem_req && !mem_ack |=> mem_req && $stable(mem_addr));

	a_wr_in_range: assert property (@(posedge CLK) disable iff (!RSTb)
		wr_en |-> int'(wr_addr) < BUF_WORDS);

endmodule

//--- verilog/scanline_ram.sv
`timescale 1ns/1ns
////////////////////
// simple dual port RAM for one scanline buffer half
// one write port, one read port with registered data
////////////////////
module scanline_ram import bg_pkg::*; #(
	parameter int ADDR_BITS = 7
) (
	input  logic                 CLK,
	input  logic                 wr_en,
	input  logic [ADDR_BITS-1:0] wr_addr,
	input  word_t                wr_data,
	input  logic [ADDR_BITS-1:0] rd_addr,
	output word_t                rd_data
);

	word_t mem [2**ADDR_BITS];

	always_ff @(posedge CLK) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];  // one cycle read latency
	end

endmodule

//--- verilog/scanline_reader.sv
`timescale 1ns/1ns
////////////////////
// display side of the scanline buffers
// reads the front half at display_x plus fine scroll and
// returns the color index two cycles later
////////////////////
module scanline_reader import bg_pkg::*; #(
	parameter  int LINE_PIXELS = 320,
	localparam int AW = $clog2((LINE_PIXELS + TILE_PIXELS) / 4)
) (
	input  logic          CLK,
	input  logic          RSTb,
	input  logic          enable,
	input  logic          h_tick,
	input  pixel_t        pal_hi,
	input  word_t         scroll_x,
	input  logic [9:0]    display_x,
	input  word_t         rd_data0,
	input  word_t         rd_data1,
	output logic [AW-1:0] rd_addr,
	output color_t        color_index
);

	logic        front;    // half being displayed, opposite to wr_buf
	logic [3:0]  fine_r;
	logic [10:0] buf_x;
	logic [1:0]  nib_sel;
	logic        front_d;
	word_t       front_word;
	pixel_t      pix;

	assign buf_x   = {1'b0, display_x} + {7'd0, fine_r};
	assign rd_addr = buf_x[AW+1:2];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			front  <= 1'b1;
			fine_r <= 4'd0;
		end else if (h_tick && enable) begin
			front  <= ~front;
			fine_r <= scroll_x[3:0];
		end
	end

	// travels alongside the RAM read
	always_ff @(posedge CLK) begin
		nib_sel <= buf_x[1:0];
		front_d <= front;
	end

	assign front_word = front_d ? rd_data1 : rd_data0;
	assign pix = front_word[{nib_sel, 2'b00} +: 4];  // lowest nibble is leftmost

	always_ff @(posedge CLK) begin
		if (!RSTb)
			color_index <= '0;
		else
			color_index <= enable ? {pal_hi, pix} : '0;
	end

endmodule

//--- verilog/bg_renderer.sv
`timescale 1ns/1ns
////////////////////
// background layer top level
// register file, line fetcher, two scanline RAM halves and the
// display reader; LINE_PIXELS is the visible width, a multiple of 16
////////////////////
module bg_renderer import bg_pkg::*; #(
	parameter int LINE_PIXELS = 320
) (
	input  logic       CLK,
	input  logic       RSTb,
	input  reg_addr_e  reg_addr,
	input  word_t      reg_wdata,
	input  logic       reg_wr,
	input  logic       h_tick,
	input  logic [9:0] line_y,
	input  logic [9:0] display_x,
	output color_t     color_index,
	output word_t      mem_addr,
	output logic       mem_req,
	input  word_t      mem_data,
	input  logic       mem_ack,
	output logic       late_line
);

	localparam int ADDR_BITS = $clog2((LINE_PIXELS + TILE_PIXELS) / 4);

	logic                 enable;
	logic [1:0]           stride_code;
	pixel_t               pal_hi;
	word_t                scroll_x;
	word_t                scroll_y;
	word_t                map_base;
	word_t                tileset_base;
	logic                 late_set;
	logic                 wr_buf;
	logic [ADDR_BITS-1:0] wr_addr;
	word_t                wr_data;
	logic                 wr_en;
	logic [ADDR_BITS-1:0] rd_addr;
	word_t                rd_data0;
	word_t                rd_data1;

	bg_regs u_regs (
		.CLK(CLK), .RSTb(RSTb),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wr(reg_wr),
		.late_set(late_set),
		.enable(enable), .stride_code(stride_code), .pal_hi(pal_hi),
		.scroll_x(scroll_x), .scroll_y(scroll_y),
		.map_base(map_base), .tileset_base(tileset_base),
		.late_line(late_line)
	);

	tile_fetcher #(.LINE_PIXELS(LINE_PIXELS)) u_fetcher (
		.CLK(CLK), .RSTb(RSTb),
		.enable(enable), .h_tick(h_tick), .line_y(line_y),
		.stride_code(stride_code), .scroll_x(scroll_x), .scroll_y(scroll_y),
		.map_base(map_base), .tileset_base(tileset_base),
		.mem_data(mem_data), .mem_ack(mem_ack),
		.mem_addr(mem_addr), .mem_req(mem_req),
		.wr_buf(wr_buf), .wr_addr(wr_addr), .wr_data(wr_data), .wr_en(wr_en),
		.late_set(late_set)
	);

	// wr_buf picks the back half being filled
	scanline_ram #(.ADDR_BITS(ADDR_BITS)) u_ram0 (
		.CLK(CLK), .wr_en(wr_en & ~wr_buf), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_data(rd_data0)
	);

	scanline_ram #(.ADDR_BITS(ADDR_BITS)) u_ram1 (
		.CLK(CLK), .wr_en(wr_en & wr_buf), .wr_addr(wr_addr), .wr_data(wr_data),
		.rd_addr(rd_addr), .rd_data(rd_data1)
	);

	scanline_reader #(.LINE_PIXELS(LINE_PIXELS)) u_reader (
		.CLK(CLK), .RSTb(RSTb),
		.enable(enable), .h_tick(h_tick), .pal_hi(pal_hi), .scroll_x(scroll_x),
		.display_x(display_x), .rd_data0(rd_data0), .rd_data1(rd_data1),
		.rd_addr(rd_addr), .color_index(color_index)
	);

endmodule

//--- include/tb_mem_image.svh
////////////////////
// memory image seen by the testbench memory model
// include inside a module that imports bg_pkg::*
////////////////////

// word at any address, mixed from all address bits
function automatic word_t mem_word(input word_t addr);
	word_t w;
	w = (addr * 16'h9E37) ^ (addr >> 5) ^ 16'h5A3C;
	if (addr[2:0] == 3'b011)
		w[7:0] = 8'hFF;   // transparent tile in the even byte
	if (addr[3:0] == 4'b1000)
		w[15:8] = 8'hFF;  // and in the odd byte
	return w;
endfunction

//--- test/bg_checker.sv
`timescale 1ns/1ns
////////////////////
// watches the background layer ports and compares the color
// output with pixels built from the address rules
////////////////////
module bg_checker import bg_pkg::*; (
	input  logic       CLK,
	input  logic       RSTb,
	input  reg_addr_e  reg_addr,
	input  word_t      reg_wdata,
	input  logic       reg_wr,
	input  logic       h_tick,
	input  logic [9:0] line_y,
	input  logic [9:0] display_x,
	input  color_t     color_index,
	input  word_t      mem_addr,
	input  logic       mem_req,
	input  logic       mem_ack,
	input  logic       late_line,
	input  logic       sweep,
	input  logic       late_check,
	input  logic       late_expect,
	output int         errors,
	output int         checks
);

	`include "tb_mem_image.svh"

	// register shadow
	logic s_en;
	logic [1:0] s_stride;
	pixel_t s_pal;
	word_t s_sx, s_sy, s_mb, s_ts;
	// line being fetched, line on display
	int f_row, f_ty, f_coarse, f_stride;
	word_t f_mb, f_ts;
	int d_row, d_ty, d_coarse, d_stride, d_fine;
	word_t d_mb, d_ts;

	logic seen_write;
	logic v1, v2;
	color_t exp1, exp2;
	logic [9:0] x1, x2;
	logic prev_open;
	word_t prev_addr;
	word_t v_sum;
	word_t ff_lo;

	function automatic pixel_t expect_pixel(input int x);
		int b, px, col, byte_a, d_a;
		word_t mw, dw;
		tile_t t;
		b = x + d_fine;
		px = b % 16;
		col = (d_coarse + b / 16) & ((32 << d_stride) - 1);  // wraps at the map stride
		byte_a = (d_mb * 2 + d_row * (32 << d_stride) + col) & 32'h1FFFF;
		mw = mem_word(16'(byte_a >> 1));
		t = byte_a[0] ? mw[15:8] : mw[7:0];
		if (t == TRANSPARENT_TILE)
			return 4'h0;
		d_a = d_ts + t[7:4] * 1024 + d_ty * 64 + t[3:0] * 4 + px / 4;
		dw = mem_word(16'(d_a));
		return dw[(px % 4) * 4 +: 4];
	endfunction

	assign v_sum = s_sy + {6'd0, line_y};
	assign ff_lo = f_ts + 16'h3C00 + 16'(f_ty * 64) + 16'd60;  // data of tile FF

	initial begin
		errors = 0;
		checks = 0;
	end

	always @(posedge CLK) begin
		if (!RSTb) begin
			s_en <= 1'b0;
			s_stride <= 2'd0;
			s_pal <= '0;
			{s_sx, s_sy, s_mb, s_ts} <= '0;
			seen_write <= 1'b0;
			v1 <= 1'b0;
			v2 <= 1'b0;
			prev_open <= 1'b0;
		end else begin
			if (!seen_write && (mem_req !== 1'b0 || late_line !== 1'b0
					|| color_index !== 8'h00)) begin
				$display("state after reset is not idle");
				errors = errors + 1;
			end
			if (reg_wr) begin
				seen_write <= 1'b1;
				case (reg_addr)
					REG_CTRL: begin
						s_en <= reg_wdata[0];
						s_stride <= reg_wdata[2:1];
						s_pal <= reg_wdata[7:4];
					end
					REG_SCROLL_X: s_sx <= reg_wdata;
					REG_SCROLL_Y: s_sy <= reg_wdata;
					REG_MAP_BASE: s_mb <= reg_wdata;
					REG_TILESET_BASE: s_ts <= reg_wdata;
					default: ;
				endcase
			end
			if (h_tick && s_en) begin
				{d_row, d_ty, d_coarse, d_stride} <= {f_row, f_ty, f_coarse, f_stride};
				d_mb <= f_mb;
				d_ts <= f_ts;
				d_fine <= int'(s_sx[3:0]);
				f_row <= int'(v_sum[15:4]);
				f_ty <= int'(v_sum[3:0]);
				f_coarse <= int'(s_sx[11:4]);
				f_stride <= int'(s_stride);
				f_mb <= s_mb;
				f_ts <= s_ts;
			end

			// two cycle display pipe
			v1 <= sweep;
			x1 <= display_x;
			exp1 <= s_en ? {s_pal, expect_pixel(int'(display_x))} : 8'h00;
			v2 <= v1;
			x2 <= x1;
			exp2 <= exp1;
			if (v2) begin
				checks = checks + 1;
				if (color_index !== exp2) begin
					$display("MISMATCH color_index x=%h got %h exp %h", x2, color_index, exp2);
					errors = errors + 1;
				end
			end

			if (prev_open) begin
				if (!mem_req) begin
					$display("mem_req dropped before mem_ack");
					errors = errors + 1;
				end else if (mem_addr !== prev_addr) begin
					$display("MISMATCH mem_addr got %h exp %h", mem_addr, prev_addr);
					errors = errors + 1;
				end
			end
			prev_open <= mem_req && !mem_ack;
			prev_addr <= mem_addr;

			if (mem_req && mem_ack && word_t'(mem_addr - ff_lo) < 16'd4) begin
				$display("tile data of transparent tile was read at %h", mem_addr);
				errors = errors + 1;
			end
			if (!s_en && mem_req) begin
				$display("memory request while disabled");
				errors = errors + 1;
			end
			if (late_check && late_line !== late_expect) begin
				$display("MISMATCH late_line got %h exp %h", late_line, late_expect);
				errors = errors + 1;
			end
		end
	end

endmodule

//--- test/tb_bg_renderer.sv
`timescale 1ns/1ns
////////////////////
// testbench for the background layer
// applies a table of line setups, models memory with random
// latency and sweeps the display while the checker compares
////////////////////
module tb_bg_renderer import bg_pkg::*; ();

	`include "tb_mem_image.svh"

	localparam int NSCEN = 7;
	localparam int LINE_W = 64;

	typedef struct {
		word_t sx;
		word_t sy;
		logic [1:0] stride;
		pixel_t pal;
		logic en;
		word_t mb;
		word_t ts;
		logic [9:0] ly;
		logic short_line;   // second tick before the fetch ends
	} scen_t;

	scen_t scenarios [NSCEN];

	logic CLK, RSTb;
	reg_addr_e reg_addr;
	word_t reg_wdata;
	logic reg_wr, h_tick;
	logic [9:0] line_y, display_x;
	color_t color_index;
	word_t mem_addr, mem_data;
	logic mem_req, mem_ack, late_line;
	logic sweep, late_check, late_expect;
	int chk_errors, chk_checks;
	int tb_errors;
	logic [31:0] lcg_state;
	logic serving;
	int delay_left;

	bg_renderer #(.LINE_PIXELS(LINE_W)) u_dut (
		.CLK(CLK), .RSTb(RSTb),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wr(reg_wr),
		.h_tick(h_tick), .line_y(line_y), .display_x(display_x),
		.color_index(color_index),
		.mem_addr(mem_addr), .mem_req(mem_req), .mem_data(mem_data), .mem_ack(mem_ack),
		.late_line(late_line)
	);

	bg_checker u_chk (
		.CLK(CLK), .RSTb(RSTb),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_wr(reg_wr),
		.h_tick(h_tick), .line_y(line_y), .display_x(display_x),
		.color_index(color_index),
		.mem_addr(mem_addr), .mem_req(mem_req), .mem_ack(mem_ack),
		.late_line(late_line),
		.sweep(sweep), .late_check(late_check), .late_expect(late_expect),
		.errors(chk_errors), .checks(chk_checks)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state >> 16);
	endfunction

	// memory answers after 0 to 5 cycles
	always @(posedge CLK) begin
		if (!RSTb) begin
			mem_ack <= 1'b0;
			serving = 1'b0;
		end else begin
			mem_ack <= 1'b0;
			if (!mem_ack && mem_req) begin
				if (!serving) begin
					serving = 1'b1;
					delay_left = int'(lcg_next() % 6);
				end
				if (delay_left == 0) begin
					mem_ack <= 1'b1;
					mem_data <= mem_word(mem_addr);
					serving = 1'b0;
				end else begin
					delay_left = delay_left - 1;
				end
			end
		end
	end

	task automatic write_reg(input reg_addr_e a, input word_t d);
		@(posedge CLK);
		reg_addr <= a;
		reg_wdata <= d;
		reg_wr <= 1'b1;
		@(posedge CLK);
		reg_wr <= 1'b0;
	endtask

	task automatic pulse_tick(input logic [9:0] y);
		@(posedge CLK);
		h_tick <= 1'b1;
		line_y <= y;
		@(posedge CLK);
		h_tick <= 1'b0;
	endtask

	// waits until mem_req has been low for a while
	task automatic wait_idle();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < 12 && n < 1500) begin
			@(posedge CLK);
			quiet = mem_req ? 0 : quiet + 1;
			n++;
		end
		if (quiet < 12) begin
			$display("fetcher did not go idle");
			tb_errors++;
		end
	endtask

	task automatic strobe_late(input logic expected);
		@(posedge CLK);
		late_check <= 1'b1;
		late_expect <= expected;
		@(posedge CLK);
		late_check <= 1'b0;
	endtask

	task automatic run_scenario(input scen_t s);
		word_t ctrl;
		ctrl = {8'h00, s.pal, 1'b0, s.stride, s.en};
		write_reg(REG_SCROLL_X, s.sx);
		write_reg(REG_SCROLL_Y, s.sy);
		write_reg(REG_MAP_BASE, s.mb);
		write_reg(REG_TILESET_BASE, s.ts);
		write_reg(REG_CTRL, ctrl);
		pulse_tick(s.ly);
		if (s.short_line) begin
			repeat (3) @(posedge CLK);
			pulse_tick(s.ly);  // aborts and refetches
			wait_idle();
			strobe_late(1'b1);
			write_reg(REG_CTRL, ctrl);
		end else begin
			wait_idle();
		end
		strobe_late(1'b0);
		pulse_tick(s.ly);  // fetched line goes to the front
		for (int x = 0; x < LINE_W; x++) begin
			@(posedge CLK);
			display_x <= 10'(x);
			sweep <= 1'b1;
		end
		@(posedge CLK);
		sweep <= 1'b0;
		wait_idle();
	endtask

	initial begin
		repeat (NSCEN * 2000) @(posedge CLK);
		$display("watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		RSTb = 1'b0;
		reg_addr = REG_CTRL;
		reg_wdata = '0;
		reg_wr = 1'b0;
		h_tick = 1'b0;
		line_y = '0;
		display_x = '0;
		mem_data = '0;
		mem_ack = 1'b0;
		sweep = 1'b0;
		late_check = 1'b0;
		late_expect = 1'b0;
		tb_errors = 0;
		lcg_state = 32'd17;

		// sx, sy, stride, pal, en, map base, tile-set base, line_y, short
		scenarios[0] = '{16'h0000, 16'h0000, 2'd0, 4'h3, 1'b1, 16'h0100, 16'h4000, 10'd0, 1'b0};
		scenarios[1] = '{16'h0005, 16'h0003, 2'd1, 4'hA, 1'b1, 16'h0100, 16'h4000, 10'd9, 1'b0};
		scenarios[2] = '{16'h0037, 16'h0021, 2'd2, 4'h5, 1'b1, 16'h0180, 16'h4400, 10'd27, 1'b0};
		scenarios[3] = '{16'h0FF3, 16'h0010, 2'd3, 4'h6, 1'b1, 16'h0100, 16'h4000, 10'd60, 1'b0};
		scenarios[4] = '{16'h0012, 16'h0000, 2'd1, 4'h7, 1'b0, 16'h0100, 16'h4000, 10'd4, 1'b0};
		scenarios[5] = '{16'h0012, 16'h0040, 2'd1, 4'hC, 1'b1, 16'h0200, 16'h4800, 10'd33, 1'b1};
		scenarios[6] = '{16'h01EC, 16'h0007, 2'd0, 4'h9, 1'b1, 16'h0100, 16'h4000, 10'd100, 1'b0};

		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;
		repeat (5) @(posedge CLK);
		for (int i = 0; i < NSCEN; i++)
			run_scenario(scenarios[i]);
		repeat (5) @(posedge CLK);

		if (chk_checks == 0) begin
			$display("no color checks were made");
			tb_errors++;
		end
		$display("color checks %0d, checker errors %0d, testbench errors %0d",
			chk_checks, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/bg_pkg.sv
verilog/bg_regs.sv
verilog/tile_fetcher.sv
verilog/scanline_ram.sv
verilog/scanline_reader.sv
verilog/bg_renderer.sv
test/bg_checker.sv
test/tb_bg_renderer.sv

//--- run_sim.sh
#!/bin/sh
# builds the background layer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_bg_renderer -o sim_bg
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_bg)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
